/* common/l2_pkg.sv */
package l2_pkg;

    localparam int ADDR_BITS = 16;
    localparam int WORD_BITS = 32;
    localparam int WORDS_PER_LINE = 4;

    // byte offset splits into word index and byte-in-word
    localparam int LINE_BITS = WORD_BITS * WORDS_PER_LINE;
    localparam int BYTE_OFF_BITS = $clog2(WORD_BITS / 8);
    localparam int WORD_OFF_BITS = $clog2(WORDS_PER_LINE);
    localparam int OFFSET_BITS = WORD_OFF_BITS + BYTE_OFF_BITS;
    localparam int LINE_ADDR_BITS = ADDR_BITS - OFFSET_BITS;

    typedef logic [WORD_BITS-1:0] word_t;
    typedef logic [LINE_BITS-1:0] line_t;
    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;

    typedef enum logic {
        CPU_READ,
        CPU_WRITE
    } cpu_msg_t;

    typedef enum logic {
        MEM_GET,
        MEM_PUT
    } mem_msg_t;

    typedef enum logic [1:0] {
        LINE_INVALID,
        LINE_VALID,
        LINE_DIRTY
    } line_state_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_EVICT,
        ST_FILL_REQ,
        ST_FILL_WAIT,
        ST_RESPOND,
        ST_FLUSH_RD,
        ST_FLUSH_WB
    } ctrl_state_t;

endpackage

/* l2/l2_input_decoder.sv */
`timescale 1ns/1ps

module l2_input_decoder #(
    parameter int L2_SETS = 8,
    parameter int L2_WAYS = 2,
    localparam int SET_BITS = $clog2(L2_SETS),
    localparam int WAY_BITS = $clog2(L2_WAYS)
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                cpu_req_valid_i,
    input  logic                flush_valid_i,
    input  logic                idle_i,
    input  logic                flush_step_i,
    output logic                cpu_req_ready_o,
    output logic                flush_ready_o,
    output logic                do_cpu_req_o,
    output logic                do_flush_o,
    output logic [SET_BITS-1:0] flush_set_o,
    output logic [WAY_BITS-1:0] flush_way_o,
    output logic                flush_last_o
);

    // flush wins over a pending cpu request
    assign flush_ready_o = idle_i;
    assign cpu_req_ready_o = idle_i && !flush_valid_i;
    assign do_flush_o = idle_i && flush_valid_i;
    assign do_cpu_req_o = cpu_req_ready_o && cpu_req_valid_i;

    assign flush_last_o = (flush_set_o == SET_BITS'(L2_SETS - 1)) &&
                          (flush_way_o == WAY_BITS'(L2_WAYS - 1));

    // way first, then set
    always_ff @(posedge clk) begin
        if (!rst_n_i || do_flush_o) begin
            flush_set_o <= '0;
            flush_way_o <= '0;
        end else if (flush_step_i) begin
            if (flush_way_o == WAY_BITS'(L2_WAYS - 1)) begin
                flush_way_o <= '0;
                if (flush_last_o) begin
                    flush_set_o <= '0;
                end else begin
                    flush_set_o <= flush_set_o + 1'b1;
                end
            end else begin
                flush_way_o <= flush_way_o + 1'b1;
            end
        end
    end

endmodule

/* l2/l2_localmem.sv */
`timescale 1ns/1ps

module l2_localmem #(
    parameter int L2_SETS = 8,
    parameter int L2_WAYS = 2,
    localparam int SET_BITS = $clog2(L2_SETS),
    localparam int WAY_BITS = $clog2(L2_WAYS),
    localparam int TAG_BITS = l2_pkg::ADDR_BITS - l2_pkg::OFFSET_BITS - SET_BITS
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic [SET_BITS-1:0]  set_in_i,
    input  logic [WAY_BITS-1:0]  way_i,
    input  logic                 wr_en_state_i,
    input  logic                 wr_en_tag_i,
    input  logic                 wr_en_line_i,
    input  l2_pkg::line_state_t  wr_data_state_i,
    input  logic [TAG_BITS-1:0]  wr_data_tag_i,
    input  l2_pkg::line_t        wr_data_line_i,
    input  logic                 evict_step_i,
    output l2_pkg::line_state_t  rd_data_state_o [L2_WAYS],
    output logic [TAG_BITS-1:0]  rd_data_tag_o [L2_WAYS],
    output l2_pkg::line_t        rd_data_line_o [L2_WAYS],
    output logic [WAY_BITS-1:0]  rd_data_evict_way_o,
    output logic                 init_done_o
);

    import l2_pkg::*;

    line_state_t         state_mem [L2_WAYS][L2_SETS];
    logic [TAG_BITS-1:0] tag_mem [L2_WAYS][L2_SETS];
    line_t               line_mem [L2_WAYS][L2_SETS];
    logic [WAY_BITS-1:0] evict_ptr [L2_SETS];
    logic [SET_BITS-1:0] init_set;

    // set-by-set clear after reset
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            init_set <= '0;
            init_done_o <= 1'b0;
        end else if (!init_done_o) begin
            init_set <= init_set + 1'b1;
            if (init_set == SET_BITS'(L2_SETS - 1)) begin
                init_done_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!init_done_o) begin
            for (int w = 0; w < L2_WAYS; w++) begin
                state_mem[w][init_set] <= LINE_INVALID;
            end
            evict_ptr[init_set] <= '0;
        end else begin
            if (wr_en_state_i) begin
                state_mem[way_i][set_in_i] <= wr_data_state_i;
            end
            // round robin per set
            if (evict_step_i) begin
                if (evict_ptr[set_in_i] == WAY_BITS'(L2_WAYS - 1)) begin
                    evict_ptr[set_in_i] <= '0;
                end else begin
                    evict_ptr[set_in_i] <= evict_ptr[set_in_i] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_tag_i) begin
            tag_mem[way_i][set_in_i] <= wr_data_tag_i;
        end
        if (wr_en_line_i) begin
            line_mem[way_i][set_in_i] <= wr_data_line_i;
        end
    end

    // read data one cycle after set_in_i
    always_ff @(posedge clk) begin
        for (int w = 0; w < L2_WAYS; w++) begin
            rd_data_state_o[w] <= state_mem[w][set_in_i];
            rd_data_tag_o[w] <= tag_mem[w][set_in_i];
            rd_data_line_o[w] <= line_mem[w][set_in_i];
        end
        rd_data_evict_way_o <= evict_ptr[set_in_i];
    end

endmodule

/* l2/l2_fsm.sv */
`timescale 1ns/1ps

module l2_fsm #(
    parameter int L2_SETS = 8,
    parameter int L2_WAYS = 2,
    localparam int SET_BITS = $clog2(L2_SETS),
    localparam int WAY_BITS = $clog2(L2_WAYS),
    localparam int TAG_BITS = l2_pkg::ADDR_BITS - l2_pkg::OFFSET_BITS - SET_BITS
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 do_cpu_req_i,
    input  logic                 do_flush_i,
    input  l2_pkg::cpu_msg_t     cpu_msg_i,
    input  l2_pkg::addr_t        cpu_addr_i,
    input  l2_pkg::word_t        cpu_wdata_i,
    input  logic [SET_BITS-1:0]  flush_set_i,
    input  logic [WAY_BITS-1:0]  flush_way_i,
    input  logic                 flush_last_i,
    input  logic                 init_done_i,
    input  l2_pkg::line_state_t  rd_data_state_i [L2_WAYS],
    input  logic [TAG_BITS-1:0]  rd_data_tag_i [L2_WAYS],
    input  l2_pkg::line_t        rd_data_line_i [L2_WAYS],
    input  logic [WAY_BITS-1:0]  rd_data_evict_way_i,
    input  logic                 rd_rsp_ready_i,
    input  logic                 req_out_ready_i,
    input  logic                 rsp_in_valid_i,
    input  l2_pkg::line_t        rsp_in_line_i,
    output logic                 idle_o,
    output logic                 flush_step_o,
    output logic                 flush_done_o,
    output logic [SET_BITS-1:0]  set_in_o,
    output logic [WAY_BITS-1:0]  way_o,
    output logic                 wr_en_state_o,
    output logic                 wr_en_tag_o,
    output logic                 wr_en_line_o,
    output l2_pkg::line_state_t  wr_data_state_o,
    output logic [TAG_BITS-1:0]  wr_data_tag_o,
    output l2_pkg::line_t        wr_data_line_o,
    output logic                 evict_step_o,
    output logic                 rd_rsp_valid_o,
    output l2_pkg::word_t        rd_rsp_word_o,
    output logic                 req_out_valid_o,
    output l2_pkg::mem_msg_t     req_out_msg_o,
    output l2_pkg::line_addr_t   req_out_addr_o,
    output l2_pkg::line_t        req_out_line_o,
    output logic                 rsp_in_ready_o
);

    import l2_pkg::*;

    ctrl_state_t              state_q, state_d;
    cpu_msg_t                 msg_q;
    addr_t                    addr_q;
    word_t                    wdata_q, word_q;
    logic [WAY_BITS-1:0]      way_q, hit_way;
    logic [TAG_BITS-1:0]      tag_q, req_tag;
    line_t                    line_q;
    logic                     dirty_q, rd_wait_q, hit, flush_go;
    logic [SET_BITS-1:0]      req_set;
    logic [WORD_OFF_BITS-1:0] word_idx;

    function automatic word_t get_word(line_t l, logic [WORD_OFF_BITS-1:0] idx);
        return l[idx*WORD_BITS +: WORD_BITS];
    endfunction

    function automatic line_t put_word(line_t l, logic [WORD_OFF_BITS-1:0] idx, word_t w);
        line_t res;
        res = l;
        res[idx*WORD_BITS +: WORD_BITS] = w;
        return res;
    endfunction

    assign req_set = addr_q[OFFSET_BITS +: SET_BITS];
    assign req_tag = addr_q[ADDR_BITS-1 -: TAG_BITS];
    assign word_idx = addr_q[BYTE_OFF_BITS +: WORD_OFF_BITS];

    always_comb begin
        hit = 1'b0;
        hit_way = '0;
        for (int w = 0; w < L2_WAYS; w++) begin
            if (rd_data_state_i[w] != LINE_INVALID && rd_data_tag_i[w] == req_tag) begin
                hit = 1'b1;
                hit_way = WAY_BITS'(w);
            end
        end
    end

    // a clean entry needs no write-back
    assign flush_go = (state_q == ST_FLUSH_WB) && (!dirty_q || req_out_ready_i);

    always_comb begin
        state_d = state_q;
        set_in_o = req_set;
        way_o = way_q;
        wr_en_state_o = 1'b0;
        wr_en_tag_o = 1'b0;
        wr_en_line_o = 1'b0;
        wr_data_state_o = LINE_VALID;
        wr_data_tag_o = req_tag;
        wr_data_line_o = rsp_in_line_i;
        evict_step_o = 1'b0;
        flush_step_o = 1'b0;
        case (state_q)
            ST_IDLE: begin
                set_in_o = do_flush_i ? flush_set_i : cpu_addr_i[OFFSET_BITS +: SET_BITS];
                if (do_flush_i) begin
                    state_d = ST_FLUSH_RD;
                end else if (do_cpu_req_i) begin
                    state_d = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (hit && msg_q == CPU_WRITE) begin
                    way_o = hit_way;
                    wr_en_line_o = 1'b1;
                    wr_data_line_o = put_word(rd_data_line_i[hit_way], word_idx, wdata_q);
                    wr_en_state_o = 1'b1;
                    wr_data_state_o = LINE_DIRTY;
                    state_d = ST_IDLE;
                end else if (hit) begin
                    state_d = ST_RESPOND;
                end else begin
                    evict_step_o = 1'b1;
                    if (rd_data_state_i[rd_data_evict_way_i] == LINE_DIRTY) begin
                        state_d = ST_EVICT;
                    end else begin
                        state_d = ST_FILL_REQ;
                    end
                end
            end
            ST_EVICT: begin
                if (req_out_ready_i) begin
                    state_d = ST_FILL_REQ;
                end
            end
            ST_FILL_REQ: begin
                if (req_out_ready_i) begin
                    state_d = ST_FILL_WAIT;
                end
            end
            ST_FILL_WAIT: begin
                if (rsp_in_valid_i) begin
                    wr_en_state_o = 1'b1;
                    wr_en_tag_o = 1'b1;
                    wr_en_line_o = 1'b1;
                    if (msg_q == CPU_WRITE) begin
                        wr_data_line_o = put_word(rsp_in_line_i, word_idx, wdata_q);
                        wr_data_state_o = LINE_DIRTY;
                        state_d = ST_IDLE;
                    end else begin
                        state_d = ST_RESPOND;
                    end
                end
            end
            ST_RESPOND: begin
                if (rd_rsp_ready_i) begin
                    state_d = ST_IDLE;
                end
            end
            ST_FLUSH_RD: begin
                set_in_o = flush_set_i;
                // new set is still on its way out of the arrays
                if (!rd_wait_q) begin
                    state_d = ST_FLUSH_WB;
                end
            end
            ST_FLUSH_WB: begin
                set_in_o = flush_set_i;
                way_o = flush_way_i;
                if (flush_go) begin
                    wr_en_state_o = 1'b1;
                    wr_data_state_o = LINE_INVALID;
                    flush_step_o = 1'b1;
                    state_d = flush_last_i ? ST_IDLE : ST_FLUSH_RD;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            rd_wait_q <= 1'b0;
            flush_done_o <= 1'b0;
        end else begin
            state_q <= state_d;
            rd_wait_q <= flush_step_o;
            flush_done_o <= flush_step_o && flush_last_i;
        end
    end

    // request and line buffers
    always_ff @(posedge clk) begin
        case (state_q)
            ST_IDLE: begin
                if (do_cpu_req_i) begin
                    msg_q <= cpu_msg_i;
                    addr_q <= cpu_addr_i;
                    wdata_q <= cpu_wdata_i;
                end
            end
            ST_LOOKUP: begin
                way_q <= rd_data_evict_way_i;
                tag_q <= rd_data_tag_i[rd_data_evict_way_i];
                line_q <= rd_data_line_i[rd_data_evict_way_i];
                word_q <= get_word(rd_data_line_i[hit_way], word_idx);
            end
            ST_FILL_WAIT: begin
                if (rsp_in_valid_i) begin
                    word_q <= get_word(rsp_in_line_i, word_idx);
                end
            end
            ST_FLUSH_RD: begin
                tag_q <= rd_data_tag_i[flush_way_i];
                line_q <= rd_data_line_i[flush_way_i];
                dirty_q <= rd_data_state_i[flush_way_i] == LINE_DIRTY;
            end
            default: ;
        endcase
    end

    assign idle_o = (state_q == ST_IDLE) && init_done_i;
    assign rd_rsp_valid_o = state_q == ST_RESPOND;
    assign rd_rsp_word_o = word_q;
    assign rsp_in_ready_o = state_q == ST_FILL_WAIT;

    assign req_out_valid_o = (state_q == ST_EVICT) || (state_q == ST_FILL_REQ) ||
                             (state_q == ST_FLUSH_WB && dirty_q);
    assign req_out_msg_o = (state_q == ST_FILL_REQ) ? MEM_GET : MEM_PUT;
    assign req_out_addr_o = (state_q == ST_FILL_REQ) ? addr_q[ADDR_BITS-1:OFFSET_BITS] :
                                                       {tag_q, set_in_o};
    assign req_out_line_o = line_q;

endmodule

/* l2/l2_core.sv */
`timescale 1ns/1ps

module l2_core (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               cpu_req_valid_i,
    output logic               cpu_req_ready_o,
    input  l2_pkg::cpu_msg_t   cpu_msg_i,
    input  l2_pkg::addr_t      cpu_addr_i,
    input  l2_pkg::word_t      cpu_wdata_i,
    output logic               rd_rsp_valid_o,
    input  logic               rd_rsp_ready_i,
    output l2_pkg::word_t      rd_rsp_word_o,
    output logic               req_out_valid_o,
    input  logic               req_out_ready_i,
    output l2_pkg::mem_msg_t   req_out_msg_o,
    output l2_pkg::line_addr_t req_out_addr_o,
    output l2_pkg::line_t      req_out_line_o,
    input  logic               rsp_in_valid_i,
    output logic               rsp_in_ready_o,
    input  l2_pkg::line_t      rsp_in_line_i,
    input  logic               flush_valid_i,
    output logic               flush_ready_o,
    output logic               flush_done_o
);

    import l2_pkg::*;

    localparam int L2_WAYS = 2;
    localparam int L2_SETS = 8;
    localparam int SET_BITS = $clog2(L2_SETS);
    localparam int WAY_BITS = $clog2(L2_WAYS);
    localparam int TAG_BITS = ADDR_BITS - OFFSET_BITS - SET_BITS;

    // decoder to fsm
    logic                idle, do_cpu_req, do_flush, flush_step, flush_last;
    logic [SET_BITS-1:0] flush_set;
    logic [WAY_BITS-1:0] flush_way;

    // fsm to local memory
    logic [SET_BITS-1:0] set_in;
    logic [WAY_BITS-1:0] way, rd_data_evict_way;
    logic                wr_en_state, wr_en_tag, wr_en_line, evict_step, init_done;
    line_state_t         wr_data_state;
    line_state_t         rd_data_state [L2_WAYS];
    logic [TAG_BITS-1:0] wr_data_tag;
    logic [TAG_BITS-1:0] rd_data_tag [L2_WAYS];
    line_t               wr_data_line;
    line_t               rd_data_line [L2_WAYS];

    l2_input_decoder #(
        .L2_SETS(L2_SETS),
        .L2_WAYS(L2_WAYS)
    ) decode_u (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .cpu_req_valid_i(cpu_req_valid_i),
        .flush_valid_i  (flush_valid_i),
        .idle_i         (idle),
        .flush_step_i   (flush_step),
        .cpu_req_ready_o(cpu_req_ready_o),
        .flush_ready_o  (flush_ready_o),
        .do_cpu_req_o   (do_cpu_req),
        .do_flush_o     (do_flush),
        .flush_set_o    (flush_set),
        .flush_way_o    (flush_way),
        .flush_last_o   (flush_last)
    );

    l2_fsm #(
        .L2_SETS(L2_SETS),
        .L2_WAYS(L2_WAYS)
    ) fsm_u (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .do_cpu_req_i       (do_cpu_req),
        .do_flush_i         (do_flush),
        .cpu_msg_i          (cpu_msg_i),
        .cpu_addr_i         (cpu_addr_i),
        .cpu_wdata_i        (cpu_wdata_i),
        .flush_set_i        (flush_set),
        .flush_way_i        (flush_way),
        .flush_last_i       (flush_last),
        .init_done_i        (init_done),
        .rd_data_state_i    (rd_data_state),
        .rd_data_tag_i      (rd_data_tag),
        .rd_data_line_i     (rd_data_line),
        .rd_data_evict_way_i(rd_data_evict_way),
        .rd_rsp_ready_i     (rd_rsp_ready_i),
        .req_out_ready_i    (req_out_ready_i),
        .rsp_in_valid_i     (rsp_in_valid_i),
        .rsp_in_line_i      (rsp_in_line_i),
        .idle_o             (idle),
        .flush_step_o       (flush_step),
        .flush_done_o       (flush_done_o),
        .set_in_o           (set_in),
        .way_o              (way),
        .wr_en_state_o      (wr_en_state),
        .wr_en_tag_o        (wr_en_tag),
        .wr_en_line_o       (wr_en_line),
        .wr_data_state_o    (wr_data_state),
        .wr_data_tag_o      (wr_data_tag),
        .wr_data_line_o     (wr_data_line),
        .evict_step_o       (evict_step),
        .rd_rsp_valid_o     (rd_rsp_valid_o),
        .rd_rsp_word_o      (rd_rsp_word_o),
        .req_out_valid_o    (req_out_valid_o),
        .req_out_msg_o      (req_out_msg_o),
        .req_out_addr_o     (req_out_addr_o),
        .req_out_line_o     (req_out_line_o),
        .rsp_in_ready_o     (rsp_in_ready_o)
    );

    l2_localmem #(
        .L2_SETS(L2_SETS),
        .L2_WAYS(L2_WAYS)
    ) localmem_u (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .set_in_i           (set_in),
        .way_i              (way),
        .wr_en_state_i      (wr_en_state),
        .wr_en_tag_i        (wr_en_tag),
        .wr_en_line_i       (wr_en_line),
        .wr_data_state_i    (wr_data_state),
        .wr_data_tag_i      (wr_data_tag),
        .wr_data_line_i     (wr_data_line),
        .evict_step_i       (evict_step),
        .rd_data_state_o    (rd_data_state),
        .rd_data_tag_o      (rd_data_tag),
        .rd_data_line_o     (rd_data_line),
        .rd_data_evict_way_o(rd_data_evict_way),
        .init_done_o        (init_done)
    );

endmodule

/* verif/l2_mem_model.sv */
`timescale 1ns/1ps

module l2_mem_model (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               stall_i,
    input  logic               req_valid_i,
    output logic               req_ready_o,
    input  l2_pkg::mem_msg_t   req_msg_i,
    input  l2_pkg::line_addr_t req_addr_i,
    input  l2_pkg::line_t      req_line_i,
    output logic               rsp_valid_o,
    input  logic               rsp_ready_i,
    output l2_pkg::line_t      rsp_line_o
);

    import l2_pkg::*;

    line_t      mem [2**LINE_ADDR_BITS];
    logic       pend;
    line_addr_t pend_addr;

    // every word starts from its own byte address
    function automatic line_t first_line(line_addr_t la);
        line_t res;
        logic [15:0] a;
        res = '0;
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            a = {la, 2'(i), 2'b00};
            res[i*WORD_BITS +: WORD_BITS] = {a ^ 16'h5a3c, ~a};
        end
        return res;
    endfunction

    initial begin
        for (int la = 0; la < 2**LINE_ADDR_BITS; la++) begin
            mem[la] = first_line(line_addr_t'(la));
        end
    end

    always @(posedge clk) begin
        if (!rst_n_i) begin
            req_ready_o <= 1'b0;
            rsp_valid_o <= 1'b0;
            rsp_line_o <= '0;
            pend <= 1'b0;
        end else begin
            // one fetch in flight at a time
            req_ready_o <= !stall_i && !pend &&
                           !(req_valid_i && req_ready_o && req_msg_i == MEM_GET);
            if (req_valid_i && req_ready_o) begin
                if (req_msg_i == MEM_PUT) begin
                    mem[req_addr_i] <= req_line_i;
                end else begin
                    pend <= 1'b1;
                    pend_addr <= req_addr_i;
                end
            end
            if (pend && !rsp_valid_o && !stall_i) begin
                rsp_valid_o <= 1'b1;
                rsp_line_o <= mem[pend_addr];
            end
            if (rsp_valid_o && rsp_ready_i) begin
                rsp_valid_o <= 1'b0;
                pend <= 1'b0;
            end
        end
    end

endmodule

/* verif/tb_l2_core.sv */
`timescale 1ns/1ps

module tb_l2_core;

    import l2_pkg::*;

    localparam int N_RANDOM = 200;
    localparam int N_SCATTER = 6;
    localparam int OP_CYCLES = 80;
    localparam int TOTAL_OPS = 2 + 2 + 4 + 2 * N_SCATTER + N_RANDOM;
    // flush walks 16 entries, margin of 2
    localparam int WATCHDOG_CYCLES = 32 + (TOTAL_OPS + 16) * OP_CYCLES * 2;

    logic clk, rst_n, stress, mem_stall;
    logic cpu_req_valid, cpu_req_ready, rd_rsp_valid, rd_rsp_ready;
    cpu_msg_t cpu_msg;
    addr_t cpu_addr;
    word_t cpu_wdata, rd_rsp_word;
    logic req_out_valid, req_out_ready, rsp_in_valid, rsp_in_ready;
    mem_msg_t req_out_msg;
    line_addr_t req_out_addr, last_get, last_put;
    line_t req_out_line, rsp_in_line;
    logic flush_valid, flush_ready, flush_done;
    word_t shadow [2**(ADDR_BITS-2)];
    logic [31:0] stim_lfsr, bg_lfsr;
    int errors, gets, puts, done_count, tests, failed_tests;
    string cur_test;

    l2_core dut0 (
        .clk(clk), .rst_n_i(rst_n),
        .cpu_req_valid_i(cpu_req_valid), .cpu_req_ready_o(cpu_req_ready),
        .cpu_msg_i(cpu_msg), .cpu_addr_i(cpu_addr), .cpu_wdata_i(cpu_wdata),
        .rd_rsp_valid_o(rd_rsp_valid), .rd_rsp_ready_i(rd_rsp_ready),
        .rd_rsp_word_o(rd_rsp_word),
        .req_out_valid_o(req_out_valid), .req_out_ready_i(req_out_ready),
        .req_out_msg_o(req_out_msg), .req_out_addr_o(req_out_addr),
        .req_out_line_o(req_out_line),
        .rsp_in_valid_i(rsp_in_valid), .rsp_in_ready_o(rsp_in_ready),
        .rsp_in_line_i(rsp_in_line),
        .flush_valid_i(flush_valid), .flush_ready_o(flush_ready),
        .flush_done_o(flush_done)
    );

    l2_mem_model mem0 (
        .clk(clk), .rst_n_i(rst_n), .stall_i(mem_stall),
        .req_valid_i(req_out_valid), .req_ready_o(req_out_ready),
        .req_msg_i(req_out_msg), .req_addr_i(req_out_addr), .req_line_i(req_out_line),
        .rsp_valid_o(rsp_in_valid), .rsp_ready_i(rsp_in_ready), .rsp_line_o(rsp_in_line)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'ha3000000) : (s >> 1);
    endfunction

    task automatic draw_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], st[0]};
            st = lfsr_step(st);
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        assert (exp == act) else begin
            $display("FAILED %s %s expected %h actual %h", cur_test, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    // memory stalls always, response back-pressure only in the stress test
    always @(posedge clk) begin
        logic [31:0] b;
        draw_bits(bg_lfsr, 2, b);
        mem_stall <= (b[1:0] == 2'b00);
        if (stress) begin
            draw_bits(bg_lfsr, 1, b);
            rd_rsp_ready <= b[0];
        end else begin
            rd_rsp_ready <= 1'b1;
        end
    end

    always @(posedge clk) begin
        if (rst_n && req_out_valid && req_out_ready) begin
            if (req_out_msg == MEM_GET) begin
                gets++;
                last_get <= req_out_addr;
            end else begin
                puts++;
                last_put <= req_out_addr;
                for (int i = 0; i < WORDS_PER_LINE; i++) begin
                    check_word("write_back", shadow[{req_out_addr, 2'(i)}],
                               req_out_line[i*WORD_BITS +: WORD_BITS]);
                end
            end
        end
        if (rst_n && flush_done) begin
            done_count++;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        rd_rsp_valid && !rd_rsp_ready |=> rd_rsp_valid && $stable(rd_rsp_word))
    else begin
        $display("rd_rsp dropped valid or changed its word before ready");
        errors++;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        req_out_valid && !req_out_ready |=> req_out_valid && $stable(req_out_msg) &&
        $stable(req_out_addr) && $stable(req_out_line))
    else begin
        $display("req_out dropped valid or changed its payload before ready");
        errors++;
    end

    assert property (@(posedge clk) disable iff (!rst_n) flush_done |=> !flush_done)
    else begin
        $display("flush_done stayed high for more than one cycle");
        errors++;
    end

    task automatic send_req(input cpu_msg_t m, input addr_t a, input word_t d);
        int n;
        n = 0;
        @(posedge clk);
        cpu_req_valid <= 1'b1;
        cpu_msg <= m;
        cpu_addr <= a;
        cpu_wdata <= d;
        @(negedge clk);
        while (!cpu_req_ready && n < OP_CYCLES) begin
            @(negedge clk);
            n++;
        end
        check_true(n < OP_CYCLES, "request was never accepted");
        @(posedge clk);
        cpu_req_valid <= 1'b0;
    endtask

    task automatic cpu_write(input addr_t a, input word_t d);
        int n;
        n = 0;
        send_req(CPU_WRITE, a, d);
        shadow[a[ADDR_BITS-1:2]] = d;
        @(negedge clk);
        while (!cpu_req_ready && n < OP_CYCLES) begin
            @(negedge clk);
            n++;
        end
        check_true(n < OP_CYCLES, "write never completed");
    endtask

    task automatic cpu_read(input addr_t a, output word_t d, output int lat);
        int n;
        n = 0;
        send_req(CPU_READ, a, '0);
        lat = 1;
        @(negedge clk);
        while (!rd_rsp_valid && lat < OP_CYCLES) begin
            @(negedge clk);
            lat++;
        end
        while (!rd_rsp_ready && n < OP_CYCLES) begin
            @(negedge clk);
            n++;
        end
        check_true(lat < OP_CYCLES && n < OP_CYCLES, "read response never arrived");
        d = rd_rsp_word;
        @(posedge clk);
    endtask

    task automatic read_expect(input string name, input addr_t a);
        word_t d;
        int lat;
        cpu_read(a, d, lat);
        check_word(name, shadow[a[ADDR_BITS-1:2]], d);
    endtask

    task automatic run_flush();
        int n;
        n = 0;
        @(posedge clk);
        flush_valid <= 1'b1;
        @(negedge clk);
        while (!flush_ready && n < OP_CYCLES) begin
            @(negedge clk);
            n++;
        end
        @(posedge clk);
        flush_valid <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!flush_done && n < 16 * OP_CYCLES) begin
            @(negedge clk);
            n++;
        end
        check_true(n < 16 * OP_CYCLES, "flush never signalled done");
        repeat (4) @(posedge clk);
    endtask

    task automatic end_test(input string name, input int err0);
        tests++;
        if (errors == err0) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: failed", name);
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * 40);
        $display("watchdog expired before the tests finished");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        int err0, g0, p0, lat;
        logic [31:0] r;
        word_t d;
        addr_t a, scatter [N_SCATTER];
        clk = 1'b0;
        rst_n = 1'b0;
        stress = 1'b0;
        mem_stall = 1'b0;
        cpu_req_valid = 1'b0;
        cpu_msg = CPU_READ;
        cpu_addr = '0;
        cpu_wdata = '0;
        rd_rsp_ready = 1'b1;
        flush_valid = 1'b0;
        stim_lfsr = 32'h4aa10277;
        bg_lfsr = 32'h4aa10277;
        errors = 0;
        gets = 0;
        puts = 0;
        done_count = 0;
        tests = 0;
        failed_tests = 0;
        cur_test = "reset";
        for (int w = 0; w < 2**(ADDR_BITS-2); w++) begin
            a = addr_t'(w << 2);
            shadow[w] = {a ^ 16'h5a3c, ~a};
        end
        repeat (15) @(posedge clk);
        @(negedge clk);
        check_true(!cpu_req_ready && !flush_ready && !rd_rsp_valid && !req_out_valid &&
                   !rsp_in_ready && !flush_done, "outputs not idle during reset");
        @(posedge clk);
        rst_n <= 1'b1;

        cur_test = "read_miss";
        err0 = errors;
        g0 = gets;
        read_expect("read_miss", 16'h0124);
        check_true(gets - g0 == 1 && last_get == 12'h012, "read miss did not issue one MEM_GET");
        end_test("read_miss", err0);

        cur_test = "write_read_hit";
        err0 = errors;
        cpu_write(16'h0208, 32'hcafe0208);
        g0 = gets + puts;
        cpu_read(16'h0208, d, lat);
        check_word("write_read_hit", 32'hcafe0208, d);
        check_word("hit_latency", 2, lat);
        check_true(gets + puts == g0, "read hit caused memory traffic");
        end_test("write_read_hit", err0);

        cur_test = "evict";
        err0 = errors;
        p0 = puts;
        cpu_write(16'h0050, 32'h11110050);
        cpu_write(16'h00d0, 32'h222200d0);
        cpu_write(16'h0150, 32'h33330150);
        check_true(puts - p0 == 1 && last_put == 12'h005, "eviction did not write back line");
        g0 = gets;
        read_expect("evict_reread", 16'h0050);
        check_true(gets - g0 == 1 && last_get == 12'h005, "re-read after eviction not fetched");
        end_test("evict", err0);

        cur_test = "flush";
        err0 = errors;
        for (int i = 0; i < N_SCATTER; i++) begin
            draw_bits(stim_lfsr, 11, r);
            scatter[i] = {r[10:2], 3'(i), r[1:0], 2'b00};
            draw_bits(stim_lfsr, 32, r);
            cpu_write(scatter[i], r);
        end
        p0 = puts;
        g0 = done_count;
        run_flush();
        check_true(puts > p0, "flush wrote back no dirty line");
        check_true(done_count - g0 == 1, "flush_done did not pulse exactly once");
        for (int i = 0; i < N_SCATTER; i++) begin
            p0 = gets;
            read_expect("flush_reread", scatter[i]);
            check_true(gets - p0 == 1, "read after flush did not miss");
        end
        end_test("flush", err0);

        cur_test = "random_mix";
        err0 = errors;
        stress = 1'b1;
        for (int i = 0; i < N_RANDOM; i++) begin
            draw_bits(stim_lfsr, 8, r);
            a = {7'b0, r[7:1], 2'b00};
            if (r[0]) begin
                draw_bits(stim_lfsr, 32, r);
                cpu_write(a, r);
            end else begin
                read_expect("random_mix", a);
            end
        end
        stress = 1'b0;
        end_test("random_mix", err0);

        repeat (4) @(posedge clk);
        $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* tb.f */
common/l2_pkg.sv
l2/l2_input_decoder.sv
l2/l2_localmem.sv
l2/l2_fsm.sv
l2/l2_core.sv
verif/l2_mem_model.sv
verif/tb_l2_core.sv

/* run.sh */
#!/bin/sh
# Build and run the L2 core testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_l2_core \
    -f tb.f \
    -o sim_tb_l2_core

./obj_dir/sim_tb_l2_core > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** FAILED ***' sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -qF '*** PASSED ***' sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
